// File: common/icache_pkg.sv
package icache_pkg;

    // --------------------------------------------------
    // geometry
    localparam int CORE_ADDR_W    = 16;
    localparam int INST_W         = 32;
    localparam int MEM_DATA_W     = 128;
    localparam int BEATS_PER_LINE = 4;
    localparam int WORDS_PER_BEAT = 4;
    localparam int SETS           = 4;
    localparam int WAYS           = 2;

    // derived widths
    localparam int SET_W       = 2;
    localparam int WAY_W       = 1;
    localparam int BEAT_W      = 2;
    localparam int WORD_W      = 4;
    localparam int TAG_W       = 10;
    localparam int MEM_ADDR_W  = 14;
    localparam int BANK_ADDR_W = 4;

    // --------------------------------------------------
    // core word address, flat or split
    typedef struct packed {
        logic [TAG_W-1:0]         tag;
        logic [SET_W-1:0]         set;
        logic [BEAT_W-1:0]        beat;
        logic [WORD_W-BEAT_W-1:0] word;
    } core_addr_fields_t;

    typedef union packed {
        logic [CORE_ADDR_W-1:0] raw;
        core_addr_fields_t      fields;
    } core_addr_u;

    typedef struct packed {
        logic       valid;
        core_addr_u addr;
    } core_req_t;

    typedef struct packed {
        logic              valid;
        logic [INST_W-1:0] inst;
    } core_rsp_t;

    typedef struct packed {
        logic                  valid;
        logic [MEM_ADDR_W-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic                  valid;
        logic [MEM_DATA_W-1:0] data;
    } mem_rsp_t;

    typedef struct packed {
        logic             hit;
        logic [WAY_W-1:0] hit_way;
        logic [WAY_W-1:0] victim_way;
    } lookup_t;

    typedef enum logic [1:0] {
        IC_READY,
        IC_MISS,
        IC_RESPOND
    } ic_state_t;

endpackage

// File: icache/icache_tags.sv
`timescale 1ns/1ps

module icache_tags (
    input  logic                         clk,
    input  logic                         rst,
    input  icache_pkg::core_addr_u       lookup_addr_i,
    output icache_pkg::lookup_t          lookup_o,
    input  logic [icache_pkg::SET_W-1:0] fill_set_i,
    input  logic [icache_pkg::TAG_W-1:0] fill_tag_i,
    input  logic [icache_pkg::WAY_W-1:0] fill_way_i,
    input  logic                         tag_write_i,
    input  logic                         invalidate_i,
    input  logic                         lru_touch_i,
    input  logic [icache_pkg::WAY_W-1:0] lru_way_i,
    input  logic [icache_pkg::SET_W-1:0] lru_set_i
);
    import icache_pkg::*;

    logic             valid_q [WAYS][SETS];
    logic [TAG_W-1:0] tag_q   [WAYS][SETS];
    logic [WAY_W-1:0] lru_q   [WAYS][SETS];

    logic [SET_W-1:0] lk_set;
    logic [TAG_W-1:0] lk_tag;
    logic [WAY_W-1:0] touched_cnt;

    assign lk_set      = lookup_addr_i.fields.set;
    assign lk_tag      = lookup_addr_i.fields.tag;
    assign touched_cnt = lru_q[lru_way_i][lru_set_i];

    // --------------------------------------------------
    // lookup
    always_comb begin
        lookup_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid_q[w][lk_set] && (tag_q[w][lk_set] == lk_tag)) begin
                lookup_o.hit     = 1'b1;
                lookup_o.hit_way = WAY_W'(w);
            end
            // oldest way is the one to replace
            if (lru_q[w][lk_set] == WAY_W'(WAYS - 1)) begin
                lookup_o.victim_way = WAY_W'(w);
            end
        end
    end

    // --------------------------------------------------
    // valid and tag arrays
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < WAYS; w++) begin
                for (int s = 0; s < SETS; s++) begin
                    valid_q[w][s] <= 1'b0;
                end
            end
        end else if (tag_write_i) begin
            valid_q[fill_way_i][fill_set_i] <= 1'b1;
        end else if (invalidate_i) begin
            // victim drops out as soon as the miss is seen
            valid_q[lookup_o.victim_way][lk_set] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_write_i) begin
            tag_q[fill_way_i][fill_set_i] <= fill_tag_i;
        end
    end

    // --------------------------------------------------
    // lru counters, start out as the way index
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < WAYS; w++) begin
                for (int s = 0; s < SETS; s++) begin
                    lru_q[w][s] <= WAY_W'(w);
                end
            end
        end else if (lru_touch_i) begin
            for (int w = 0; w < WAYS; w++) begin
                if (lru_q[w][lru_set_i] < touched_cnt) begin
                    lru_q[w][lru_set_i] <= lru_q[w][lru_set_i] + 1'b1;
                end
            end
            lru_q[lru_way_i][lru_set_i] <= '0;
        end
    end

    // a line never lives in two ways of its set
    for (genvar s = 0; s < SETS; s++) begin : g_dup_set
        for (genvar a = 0; a < WAYS - 1; a++) begin : g_dup_a
            for (genvar b = a + 1; b < WAYS; b++) begin : g_dup_b
                a_no_dup_tag: assert property (@(posedge clk) disable iff (rst)
                    !(valid_q[a][s] && valid_q[b][s] && (tag_q[a][s] == tag_q[b][s])));
            end
        end
    end

endmodule

// File: icache/icache_data.sv
`timescale 1ns/1ps

module icache_data (
    input  logic                              clk,
    input  logic [icache_pkg::WAY_W-1:0]      rd_way_i,
    input  icache_pkg::core_addr_u            rd_addr_i,
    input  logic                              wr_en_i,
    input  logic [icache_pkg::WAY_W-1:0]      wr_way_i,
    input  logic [icache_pkg::SET_W-1:0]      wr_set_i,
    input  logic [icache_pkg::BEAT_W-1:0]     wr_beat_i,
    input  logic [icache_pkg::MEM_DATA_W-1:0] wr_data_i,
    output logic [icache_pkg::INST_W-1:0]     word_o
);
    import icache_pkg::*;

    typedef logic [WORDS_PER_BEAT-1:0][INST_W-1:0] beat_t;

    // one bank per way, indexed by set then beat
    beat_t bank [WAYS][SETS*BEATS_PER_LINE];

    beat_t                    rd_beat_q [WAYS];
    logic [BANK_ADDR_W-1:0]   wr_addr;
    logic [BANK_ADDR_W-1:0]   rd_addr;
    logic [WAY_W-1:0]         way_q;
    logic [WORD_W-BEAT_W-1:0] word_q;
    beat_t                    sel_beat;

    assign wr_addr = {wr_set_i, wr_beat_i};
    assign rd_addr = {rd_addr_i.fields.set, rd_addr_i.fields.beat};

    // --------------------------------------------------
    // bank write and synchronous read
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (wr_en_i && (wr_way_i == WAY_W'(w))) begin
                bank[w][wr_addr] <= wr_data_i;
            end
            rd_beat_q[w] <= bank[w][rd_addr];
        end
    end

    // select info follows the read by one cycle
    always_ff @(posedge clk) begin
        way_q  <= rd_way_i;
        word_q <= rd_addr_i.fields.word;
    end

    // --------------------------------------------------
    // word select
    assign sel_beat = rd_beat_q[way_q];
    assign word_o   = sel_beat[word_q];

endmodule

// File: hdl/fill_counter.sv
`timescale 1ns/1ps

module fill_counter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          clear_i,
    input  logic                          req_step_i,
    input  logic                          rsp_step_i,
    output logic [icache_pkg::BEAT_W-1:0] req_beat_o,
    output logic [icache_pkg::BEAT_W-1:0] rsp_beat_o,
    output logic                          last_rsp_o
);
    import icache_pkg::*;

    // one extra bit tells a full line apart from an empty one
    logic [BEAT_W:0] req_cnt_q;
    logic [BEAT_W:0] rsp_cnt_q;

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            req_cnt_q <= '0;
            rsp_cnt_q <= '0;
        end else begin
            if (req_step_i) begin
                req_cnt_q <= req_cnt_q + 1'b1;
            end
            if (rsp_step_i) begin
                rsp_cnt_q <= rsp_cnt_q + 1'b1;
            end
        end
    end

    assign req_beat_o = req_cnt_q[BEAT_W-1:0];
    assign rsp_beat_o = rsp_cnt_q[BEAT_W-1:0];
    assign last_rsp_o = (rsp_cnt_q == (BEAT_W + 1)'(BEATS_PER_LINE - 1));

    // memory only answers beats that were asked for
    a_rsp_after_req: assert property (@(posedge clk) disable iff (rst)
        rsp_step_i |-> (rsp_cnt_q < req_cnt_q));

endmodule

// File: hdl/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  icache_pkg::core_req_t        core_req_i,
    output logic                         req_ready_o,
    output logic                         core_rsp_valid_o,
    input  icache_pkg::lookup_t          lookup_i,
    output icache_pkg::mem_req_t         mem_req_o,
    input  logic                         mem_rsp_valid_i,
    input  logic [icache_pkg::BEAT_W-1:0] req_beat_i,
    input  logic                         last_rsp_i,
    output logic                         counter_clear_o,
    output logic                         req_step_o,
    output logic                         rsp_step_o,
    output icache_pkg::core_addr_u       lookup_addr_o,
    output logic [icache_pkg::WAY_W-1:0] data_rd_way_o,
    output icache_pkg::core_addr_u       data_rd_addr_o,
    output logic [icache_pkg::WAY_W-1:0] fill_way_o,
    output logic [icache_pkg::SET_W-1:0] fill_set_o,
    output logic [icache_pkg::TAG_W-1:0] fill_tag_o,
    output logic                         tag_write_o,
    output logic                         invalidate_o,
    output logic                         lru_touch_o,
    output logic [icache_pkg::WAY_W-1:0] lru_way_o,
    output logic [icache_pkg::SET_W-1:0] lru_set_o,
    output logic                         data_wr_en_o
);
    import icache_pkg::*;

    typedef struct packed {
        core_addr_u       addr;
        logic             hit;
        logic [WAY_W-1:0] victim;
    } req_reg_t;

    ic_state_t state_q, state_d;
    req_reg_t  req_q;
    logic      req_valid_q, req_busy_q, fill_done_q;
    logic      accept, miss_now, last_req, in_ready, in_respond;

    assign in_ready    = (state_q == IC_READY);
    assign in_respond  = (state_q == IC_RESPOND);
    assign req_ready_o = in_ready;
    assign accept      = core_req_i.valid && in_ready;
    assign miss_now    = accept && !lookup_i.hit;
    assign last_req    = req_busy_q && (req_beat_i == BEAT_W'(BEATS_PER_LINE - 1));

    // --------------------------------------------------
    // request register, also holds the pending miss while not ready
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= '{addr: core_req_i.addr, hit: lookup_i.hit, victim: lookup_i.victim_way};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= IC_READY;
            req_valid_q <= 1'b0;
            req_busy_q  <= 1'b0;
            fill_done_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            req_valid_q <= accept;
            fill_done_q <= in_respond;
            if (miss_now) begin
                req_busy_q <= 1'b1;
            end else if (last_req) begin
                req_busy_q <= 1'b0;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IC_READY:   if (miss_now) state_d = IC_MISS;
            IC_MISS:    if (tag_write_o) state_d = IC_RESPOND;
            IC_RESPOND: state_d = IC_READY;
            default:    state_d = IC_READY;
        endcase
    end

    // --------------------------------------------------
    // core and memory strobes
    assign core_rsp_valid_o = (req_valid_q && req_q.hit) || fill_done_q;
    assign mem_req_o.valid  = req_busy_q;
    assign mem_req_o.addr   = {req_q.addr.raw[CORE_ADDR_W-1:WORD_W], req_beat_i};
    assign req_step_o       = req_busy_q;
    assign rsp_step_o       = (state_q == IC_MISS) && mem_rsp_valid_i;
    assign counter_clear_o  = in_respond;

    // fill steering
    assign data_wr_en_o = rsp_step_o;
    assign tag_write_o  = rsp_step_o && last_rsp_i;
    assign fill_way_o   = req_q.victim;
    assign fill_set_o   = req_q.addr.fields.set;
    assign fill_tag_o   = req_q.addr.fields.tag;
    assign invalidate_o = miss_now;

    // lru touch on a hit or once the fill is in
    assign lru_touch_o = (accept && lookup_i.hit) || in_respond;
    assign lru_way_o   = in_respond ? req_q.victim : lookup_i.hit_way;
    assign lru_set_o   = in_respond ? req_q.addr.fields.set : core_req_i.addr.fields.set;

    assign lookup_addr_o  = core_req_i.addr;
    assign data_rd_way_o  = in_ready ? lookup_i.hit_way : req_q.victim;
    assign data_rd_addr_o = in_ready ? core_req_i.addr : req_q.addr;

    a_mem_req_in_miss: assert property (@(posedge clk) disable iff (rst)
        (state_q != IC_MISS) |-> !mem_req_o.valid);

endmodule

// File: hdl/icache_top.sv
`timescale 1ns/1ps

module icache_top (
    input  logic                  clk,
    input  logic                  rst,
    input  icache_pkg::core_req_t core_req_i,
    output logic                  req_ready_o,
    output icache_pkg::core_rsp_t core_rsp_o,
    output icache_pkg::mem_req_t  mem_req_o,
    input  icache_pkg::mem_rsp_t  mem_rsp_i
);
    import icache_pkg::*;

    lookup_t           lookup;
    core_addr_u        lookup_addr;
    core_addr_u        data_rd_addr;
    logic [WAY_W-1:0]  data_rd_way;
    logic [WAY_W-1:0]  fill_way;
    logic [SET_W-1:0]  fill_set;
    logic [TAG_W-1:0]  fill_tag;
    logic [WAY_W-1:0]  lru_way;
    logic [SET_W-1:0]  lru_set;
    logic              tag_write, invalidate, lru_touch, data_wr_en;
    logic              counter_clear, req_step, rsp_step, last_rsp;
    logic [BEAT_W-1:0] req_beat, rsp_beat;
    logic              core_rsp_valid;
    logic [INST_W-1:0] word;

    assign core_rsp_o.valid = core_rsp_valid;
    assign core_rsp_o.inst  = word;

    // --------------------------------------------------
    icache_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .core_req_i       (core_req_i),
        .req_ready_o      (req_ready_o),
        .core_rsp_valid_o (core_rsp_valid),
        .lookup_i         (lookup),
        .mem_req_o        (mem_req_o),
        .mem_rsp_valid_i  (mem_rsp_i.valid),
        .req_beat_i       (req_beat),
        .last_rsp_i       (last_rsp),
        .counter_clear_o  (counter_clear),
        .req_step_o       (req_step),
        .rsp_step_o       (rsp_step),
        .lookup_addr_o    (lookup_addr),
        .data_rd_way_o    (data_rd_way),
        .data_rd_addr_o   (data_rd_addr),
        .fill_way_o       (fill_way),
        .fill_set_o       (fill_set),
        .fill_tag_o       (fill_tag),
        .tag_write_o      (tag_write),
        .invalidate_o     (invalidate),
        .lru_touch_o      (lru_touch),
        .lru_way_o        (lru_way),
        .lru_set_o        (lru_set),
        .data_wr_en_o     (data_wr_en)
    );

    icache_tags u_tags (
        .clk           (clk),
        .rst           (rst),
        .lookup_addr_i (lookup_addr),
        .lookup_o      (lookup),
        .fill_set_i    (fill_set),
        .fill_tag_i    (fill_tag),
        .fill_way_i    (fill_way),
        .tag_write_i   (tag_write),
        .invalidate_i  (invalidate),
        .lru_touch_i   (lru_touch),
        .lru_way_i     (lru_way),
        .lru_set_i     (lru_set)
    );

    icache_data u_data (
        .clk       (clk),
        .rd_way_i  (data_rd_way),
        .rd_addr_i (data_rd_addr),
        .wr_en_i   (data_wr_en),
        .wr_way_i  (fill_way),
        .wr_set_i  (fill_set),
        .wr_beat_i (rsp_beat),
        .wr_data_i (mem_rsp_i.data),
        .word_o    (word)
    );

    fill_counter u_fill_counter (
        .clk        (clk),
        .rst        (rst),
        .clear_i    (counter_clear),
        .req_step_i (req_step),
        .rsp_step_i (rsp_step),
        .req_beat_o (req_beat),
        .rsp_beat_o (rsp_beat),
        .last_rsp_o (last_rsp)
    );

endmodule

// File: tb/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;
    import icache_pkg::*;

    localparam int LINE_WORDS = BEATS_PER_LINE * WORDS_PER_BEAT;
    // seven fills of about 12 cycles, some 40 hits, the burst and reset
    // come to roughly 250 cycles
    localparam int MAX_CYCLES = 2000;
    localparam int RSP_WAIT   = 40;

    logic      clk = 1'b0;
    logic      rst;
    core_req_t core_req;
    logic      req_ready;
    core_rsp_t core_rsp;
    mem_req_t  mem_req;
    mem_rsp_t  mem_rsp;

    int     cycle = 0;
    integer seed = 32'heae;

    // memory model state
    logic [MEM_ADDR_W-1:0] req_log [$];
    int                    req_due [$];
    int                    last_due = 0;
    int                    served = 0;

    icache_top UUT (
        .clk         (clk),
        .rst         (rst),
        .core_req_i  (core_req),
        .req_ready_o (req_ready),
        .core_rsp_o  (core_rsp),
        .mem_req_o   (mem_req),
        .mem_rsp_i   (mem_rsp)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            stop_with_error($sformatf("timeout, run went past %0d cycles", MAX_CYCLES));
        end
    end

    // --------------------------------------------------
    // data rule and address helpers
    function automatic logic [INST_W-1:0] expected_inst(input logic [CORE_ADDR_W-1:0] addr);
        return {16'ha5a5, addr};
    endfunction

    function automatic logic [MEM_DATA_W-1:0] beat_data(
        input logic [MEM_ADDR_W-1:0] beat_addr);
        logic [MEM_DATA_W-1:0] data;
        for (int i = 0; i < WORDS_PER_BEAT; i++) begin
            data[i*INST_W +: INST_W] = expected_inst({beat_addr, BEAT_W'(i)});
        end
        return data;
    endfunction

    function automatic logic [CORE_ADDR_W-1:0] word_addr(input int tag, input int set,
                                                         input int word);
        return {TAG_W'(tag), SET_W'(set), WORD_W'(word)};
    endfunction

    // --------------------------------------------------
    // memory model
    // requests are taken at the rising edge, beats come back in order
    always @(posedge clk) begin : mem_accept
        int due;
        if (!rst && mem_req.valid) begin
            due = cycle + 1 + int'($unsigned($random(seed)) % 3);
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            req_log.push_back(mem_req.addr);
            req_due.push_back(due);
        end
    end

    initial begin : mem_respond
        mem_rsp = '0;
        forever begin
            @(negedge clk);
            if (served < req_log.size() && req_due[served] <= cycle) begin
                mem_rsp.valid = 1'b1;
                mem_rsp.data  = beat_data(req_log[served]);
                served++;
            end else begin
                mem_rsp = '0;
            end
        end
    end

    // --------------------------------------------------
    // compare tasks
    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic inst_equal(input string name, input logic [INST_W-1:0] got,
                              input logic [INST_W-1:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic beat_addr_equal(input string name, input logic [MEM_ADDR_W-1:0] got,
                                   input logic [MEM_ADDR_W-1:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic count_equal(input string name, input int got, input int exp);
        if (got !== exp) begin
            stop_with_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic flag_equal(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    // --------------------------------------------------
    // request helpers
    task automatic fetch(input logic [CORE_ADDR_W-1:0] addr, output int latency,
                         output logic [INST_W-1:0] inst);
        flag_equal("req_ready_o", req_ready, 1'b1);
        core_req.valid    = 1'b1;
        core_req.addr.raw = addr;
        @(negedge clk);
        core_req.valid = 1'b0;
        latency = 1;
        while (!core_rsp.valid) begin
            if (latency >= RSP_WAIT) begin
                stop_with_error("no core response arrived within the wait limit");
            end else begin
                @(negedge clk);
                latency++;
            end
        end
        inst = core_rsp.inst;
    endtask

    task automatic fill_line(input logic [CORE_ADDR_W-1:0] addr);
        int                first;
        int                latency;
        logic [INST_W-1:0] inst;
        first = req_log.size();
        fetch(addr, latency, inst);
        inst_equal("core_rsp_o.inst", inst, expected_inst(addr));
        count_equal("memory requests", req_log.size() - first, BEATS_PER_LINE);
        // first beat of the line, then one up per request
        for (int i = 0; i < BEATS_PER_LINE; i++) begin
            beat_addr_equal("mem_req_o.addr", req_log[first + i],
                            MEM_ADDR_W'(addr / LINE_WORDS * BEATS_PER_LINE + i));
        end
    endtask

    task automatic hit_once(input logic [CORE_ADDR_W-1:0] addr);
        int                first;
        int                latency;
        logic [INST_W-1:0] inst;
        first = req_log.size();
        fetch(addr, latency, inst);
        count_equal("hit latency", latency, 1);
        inst_equal("core_rsp_o.inst", inst, expected_inst(addr));
        // a wrong miss shows its first request one edge later
        @(negedge clk);
        count_equal("memory requests", req_log.size() - first, 0);
    endtask

    // one request per cycle, each answer checked in the cycle after
    task automatic hit_burst(input int tag, input int set);
        int first;
        first = req_log.size();
        for (int k = 0; k <= LINE_WORDS; k++) begin
            if (k > 0) begin
                flag_equal("core_rsp_o.valid", core_rsp.valid, 1'b1);
                inst_equal("core_rsp_o.inst", core_rsp.inst,
                           expected_inst(word_addr(tag, set, k - 1)));
            end
            if (k < LINE_WORDS) begin
                flag_equal("req_ready_o", req_ready, 1'b1);
                core_req.valid    = 1'b1;
                core_req.addr.raw = word_addr(tag, set, k);
            end else begin
                core_req.valid = 1'b0;
            end
            @(negedge clk);
        end
        count_equal("memory requests", req_log.size() - first, 0);
    endtask

    // --------------------------------------------------
    // directed tests
    task automatic after_reset();
        flag_equal("req_ready_o", req_ready, 1'b1);
        flag_equal("core_rsp_o.valid", core_rsp.valid, 1'b0);
        flag_equal("mem_req_o.valid", mem_req.valid, 1'b0);
        count_equal("memory requests", req_log.size(), 0);
    endtask

    task automatic cold_miss();
        fill_line(word_addr(18, 1, 6));
    endtask

    task automatic line_hits();
        for (int w = 0; w < LINE_WORDS; w++) begin
            hit_once(word_addr(18, 1, w));
        end
        hit_burst(18, 1);
    endtask

    task automatic two_tags_one_set();
        fill_line(word_addr(64, 2, 3));
        fill_line(word_addr(129, 2, 9));
        hit_once(word_addr(64, 2, 14));
        hit_once(word_addr(129, 2, 0));
        hit_once(word_addr(64, 2, 3));
    endtask

    // A, B, A, then C takes the way of B
    task automatic lru_replacement();
        fill_line(word_addr(5, 3, 1));
        fill_line(word_addr(6, 3, 2));
        hit_once(word_addr(5, 3, 7));
        fill_line(word_addr(7, 3, 4));
        hit_once(word_addr(5, 3, 1));
        fill_line(word_addr(6, 3, 2));
    endtask

    initial begin
        rst      = 1'b1;
        core_req = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        after_reset();
        cold_miss();
        line_hits();
        two_tags_one_set();
        lru_replacement();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: icache_top.f
common/icache_pkg.sv
icache/icache_tags.sv
icache/icache_data.sv
hdl/fill_counter.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
tb/icache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= icache_tb
FLIST     ?= icache_top.f
SEED      ?= 1
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --assert -j 0 --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(OBJ_DIR)
